//--- clic_consts.svh
// ----------------------------
// Sizing constants for the CLIC-style interrupt subsystem
// Include where a width or count is needed
// ----------------------------

`ifndef CLIC_CONSTS_SVH
`define CLIC_CONSTS_SVH

// Number of interrupt sources, power of two for the arbiter tree
`define CLIC_NUM_SRC 16

// Source id width, log2 of the source count
`define CLIC_ID_W 4

`define CLIC_LEVEL_W 8  // Interrupt level width
`define CLIC_XLEN 32    // Register width of the hart

`endif

//--- clic_core_ctrl.sv
// ----------------------------
// Core side of the CLIC: threshold check, cause packing and
// in-flight tracking to grant or hold off kill requests
// ----------------------------

`include "clic_consts.svh"

module clic_core_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  clic_pkg::priv_lvl_e      priv_lvl_i,    // Current hart privilege
  input  logic [`CLIC_LEVEL_W-1:0] mintthresh_i,
  input  logic [`CLIC_LEVEL_W-1:0] sintthresh_i,
  input  clic_pkg::intstatus_u     mintstatus_i,
  input  logic                     sie_i,         // S-mode global enable
  input  logic                     irq_ack_i,     // Pipeline took the irq
  clic_irq_if.core                 irq,
  output logic                     irq_req_o,
  output logic [`CLIC_XLEN-1:0]    irq_cause_o
);

  logic [`CLIC_LEVEL_W-1:0] eff_mthresh;
  logic [`CLIC_LEVEL_W-1:0] eff_sthresh;
  logic                     inflight_q, inflight_d;

  // ----------------------------
  // Trigger
  // ----------------------------
  // Active level counts as a threshold too
  assign eff_mthresh = (mintthresh_i > mintstatus_i.fields.mil) ? mintthresh_i
                                                                : mintstatus_i.fields.mil;
  assign eff_sthresh = (sintthresh_i > mintstatus_i.fields.sil) ? sintthresh_i
                                                                : mintstatus_i.fields.sil;

  always_comb begin
    irq_req_o = 1'b0;
    case (priv_lvl_i)
      clic_pkg::PRIV_M: begin
        // Only M sources above threshold
        if (irq.priv == clic_pkg::PRIV_M) begin
          irq_req_o = irq.valid && (irq.level > eff_mthresh);
        end
      end
      clic_pkg::PRIV_S: begin
        if (irq.priv == clic_pkg::PRIV_M) begin
          irq_req_o = irq.valid;  // Higher privilege always preempts
        end else if (irq.priv == clic_pkg::PRIV_S) begin
          irq_req_o = irq.valid && sie_i && (irq.level > eff_sthresh);
        end
      end
      clic_pkg::PRIV_U: irq_req_o = irq.valid;  // Everything fires
      default: irq_req_o = 1'b0;
    endcase
  end

  // ----------------------------
  // Cause packing
  // ----------------------------
  assign irq_cause_o = {
    1'b1,                                               // Interrupt flag
    {(`CLIC_XLEN - 1 - `CLIC_LEVEL_W - 16){1'b0}},
    irq.level,                                          // Bits 23..16
    {(16 - `CLIC_ID_W){1'b0}},
    irq.id                                              // Source id
  };

  // ----------------------------
  // Kill control
  // ----------------------------
  assign irq.ready = irq_ack_i;

  // No kill while the pipeline may still take the current offer
  assign irq.kill_ack = irq.kill_req & ~inflight_q & ~irq_req_o;

  // Set on an unacked request, clear on ack or kill
  assign inflight_d = inflight_q ? ~(irq_ack_i | irq.kill_ack)
                                 : (irq_req_o & ~irq_ack_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

//--- clic_csr_regs.sv
// ----------------------------
// Interrupt CSRs: thresholds, status, S-mode enable and mcause
// Written by single-cycle strobe, updated when an irq is taken
// ----------------------------

`include "clic_consts.svh"

module clic_csr_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     csr_we_i,
  input  clic_pkg::csr_sel_e       csr_sel_i,
  input  logic [`CLIC_XLEN-1:0]    csr_wdata_i,
  input  logic                     take_i,        // Request accepted this cycle
  input  logic [`CLIC_XLEN-1:0]    take_cause_i,
  input  clic_pkg::priv_lvl_e      take_priv_i,
  input  logic [`CLIC_LEVEL_W-1:0] take_level_i,
  output logic [`CLIC_LEVEL_W-1:0] mintthresh_o,
  output logic [`CLIC_LEVEL_W-1:0] sintthresh_o,
  output clic_pkg::intstatus_u     mintstatus_o,
  output logic                     sie_o,
  output logic [`CLIC_XLEN-1:0]    mcause_o
);

  logic [`CLIC_LEVEL_W-1:0] mthresh_q, mthresh_d;
  logic [`CLIC_LEVEL_W-1:0] sthresh_q, sthresh_d;
  clic_pkg::intstatus_u     status_q, status_d;
  logic                     sie_q, sie_d;
  logic [`CLIC_XLEN-1:0]    mcause_q, mcause_d;

  // Next state, irq capture before software writes
  always_comb begin
    mthresh_d = mthresh_q;
    sthresh_d = sthresh_q;
    status_d  = status_q;
    sie_d     = sie_q;
    mcause_d  = mcause_q;
    if (take_i) begin
      mcause_d = take_cause_i;
      if (take_priv_i == clic_pkg::PRIV_M) begin
        status_d.fields.mil = take_level_i;
      end else if (take_priv_i == clic_pkg::PRIV_S) begin
        status_d.fields.sil = take_level_i;
      end
    end else if (csr_we_i) begin
      case (csr_sel_i)
        clic_pkg::CSR_MINTTHRESH: mthresh_d = csr_wdata_i[`CLIC_LEVEL_W-1:0];
        clic_pkg::CSR_SINTTHRESH: sthresh_d = csr_wdata_i[`CLIC_LEVEL_W-1:0];
        clic_pkg::CSR_MINTSTATUS: begin
          status_d.raw         = csr_wdata_i;
          status_d.fields.zero = '0;  // Reserved byte stays clear
        end
        clic_pkg::CSR_SIE: sie_d = csr_wdata_i[0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mthresh_q <= '0;
      sthresh_q <= '0;
      status_q  <= '0;
      sie_q     <= 1'b0;
      mcause_q  <= '0;
    end else begin
      mthresh_q <= mthresh_d;
      sthresh_q <= sthresh_d;
      status_q  <= status_d;
      sie_q     <= sie_d;
      mcause_q  <= mcause_d;
    end
  end

  assign mintthresh_o = mthresh_q;
  assign sintthresh_o = sthresh_q;
  assign mintstatus_o = status_q;
  assign sie_o        = sie_q;
  assign mcause_o     = mcause_q;

endmodule

//--- clic_irq_if.sv
// ----------------------------
// Handshake between source arbiter and core controller
// Arbiter offers one source, core takes it or grants a kill
// ----------------------------

`include "clic_consts.svh"

interface clic_irq_if;

  // Offer, stable while valid is up
  logic                     valid;
  logic [`CLIC_ID_W-1:0]    id;
  logic [`CLIC_LEVEL_W-1:0] level;
  clic_pkg::priv_lvl_e      priv;

  // Preemption request, held until kill_ack
  logic kill_req;

  // Core side responses
  logic ready;     // One-cycle pulse, offer taken
  logic kill_ack;  // Offer withdrawn

  modport arb (
    output valid, id, level, priv, kill_req,
    input  ready, kill_ack
  );

  modport core (
    input  valid, id, level, priv, kill_req,
    output ready, kill_ack
  );

endinterface

//--- clic_pkg.sv
// ----------------------------
// Shared types for the CLIC-style interrupt subsystem
// Privilege, CSR select and the interrupt status word
// ----------------------------

`include "clic_consts.svh"

package clic_pkg;

  // Privilege levels, encoding as in the RISC-V spec
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_lvl_e;

  // Which CSR a write strobe targets
  typedef enum logic [1:0] {
    CSR_MINTTHRESH = 2'd0,
    CSR_SINTTHRESH = 2'd1,
    CSR_MINTSTATUS = 2'd2,
    CSR_SIE        = 2'd3
  } csr_sel_e;

  // Interrupt status word, MSB first
  typedef struct packed {
    logic [`CLIC_LEVEL_W-1:0] mil;   // M-mode active level
    logic [`CLIC_LEVEL_W-1:0] zero;  // Reserved, reads 0
    logic [`CLIC_LEVEL_W-1:0] sil;   // S-mode active level
    logic [`CLIC_LEVEL_W-1:0] uil;   // U-mode active level
  } intstatus_fields_t;

  // Raw view for CSR access, field view for the level logic
  typedef union packed {
    logic [`CLIC_XLEN-1:0] raw;
    intstatus_fields_t     fields;
  } intstatus_u;

endpackage

//--- clic_source_arbiter.sv
// ----------------------------
// Source side of the CLIC with edge-latched pending bits, per-source config,
// max-level selection and preemption kill requests
// ----------------------------

`include "clic_consts.svh"

module clic_source_arbiter (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic [`CLIC_NUM_SRC-1:0] src_i,        // Edge strobes
  input  logic                     cfg_we_i,
  input  logic [`CLIC_ID_W-1:0]    cfg_id_i,
  input  logic                     cfg_ie_i,
  input  logic [`CLIC_LEVEL_W-1:0] cfg_level_i,
  input  clic_pkg::priv_lvl_e      cfg_priv_i,
  clic_irq_if.arb                  irq
);

  localparam int unsigned num_nodes = 2 * `CLIC_NUM_SRC - 1;

  // Per-source state
  logic [`CLIC_NUM_SRC-1:0] pending_q, pending_d;
  logic [`CLIC_NUM_SRC-1:0] ie_q;
  logic [`CLIC_LEVEL_W-1:0] level_q [`CLIC_NUM_SRC];
  clic_pkg::priv_lvl_e      priv_q  [`CLIC_NUM_SRC];
  logic [`CLIC_NUM_SRC-1:0] eligible;

  // Selection tree nodes with leaves at num_nodes-CLIC_NUM_SRC and up
  logic                     node_valid [num_nodes];
  logic [`CLIC_ID_W-1:0]    node_id    [num_nodes];
  logic [`CLIC_LEVEL_W-1:0] node_level [num_nodes];
  clic_pkg::priv_lvl_e      node_priv  [num_nodes];

  // Offer register
  logic                     valid_q, valid_d;
  logic                     kill_q, kill_d;
  logic [`CLIC_ID_W-1:0]    sel_id_q;
  logic [`CLIC_LEVEL_W-1:0] sel_level_q;
  clic_pkg::priv_lvl_e      sel_priv_q;
  logic                     taken;

  // ----------------------------
  // Pending and configuration
  // ----------------------------
  assign taken = valid_q & irq.ready;

  always_comb begin
    pending_d = pending_q;
    if (taken) pending_d[sel_id_q] = 1'b0;  // Offer consumed
    pending_d = pending_d | src_i;           // New strobe wins over clear
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
      ie_q      <= '0;
    end else begin
      pending_q <= pending_d;
      if (cfg_we_i) ie_q[cfg_id_i] <= cfg_ie_i;
    end
  end

  // Per-source level and privilege from the config strobe
  always_ff @(posedge clk_i) begin
    if (cfg_we_i) begin
      level_q[cfg_id_i] <= cfg_level_i;
      priv_q[cfg_id_i]  <= cfg_priv_i;
    end
  end

  assign eligible = pending_q & ie_q;

  // ----------------------------
  // Max-level selection tree
  // ----------------------------
  always_comb begin
    logic pick_hi;
    // Leaves masked so idle sources carry no level
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      node_valid[`CLIC_NUM_SRC-1+i] = eligible[i] && (level_q[i] != '0);
      node_id[`CLIC_NUM_SRC-1+i]    = i[`CLIC_ID_W-1:0];
      node_level[`CLIC_NUM_SRC-1+i] = node_valid[`CLIC_NUM_SRC-1+i] ? level_q[i] : '0;
      node_priv[`CLIC_NUM_SRC-1+i]  = node_valid[`CLIC_NUM_SRC-1+i] ? priv_q[i]
                                                                    : clic_pkg::PRIV_M;
    end
    // Inner nodes bottom up with the right child holding higher ids
    for (int k = `CLIC_NUM_SRC - 2; k >= 0; k--) begin
      pick_hi = node_valid[2*k+2] &&
                (!node_valid[2*k+1] || node_level[2*k+2] >= node_level[2*k+1]);
      node_valid[k] = node_valid[2*k+1] | node_valid[2*k+2];
      node_id[k]    = pick_hi ? node_id[2*k+2]    : node_id[2*k+1];
      node_level[k] = pick_hi ? node_level[2*k+2] : node_level[2*k+1];
      node_priv[k]  = pick_hi ? node_priv[2*k+2]  : node_priv[2*k+1];
    end
  end

  // ----------------------------
  // Offer and kill control
  // ----------------------------
  always_comb begin
    valid_d = valid_q;
    kill_d  = kill_q;
    if (!valid_q) begin
      valid_d = node_valid[0];  // Load best candidate
      kill_d  = 1'b0;
    end else if (irq.ready || irq.kill_ack) begin
      valid_d = 1'b0;           // Reselect next cycle
      kill_d  = 1'b0;
    end else if (node_valid[0] && node_level[0] > sel_level_q) begin
      kill_d  = 1'b1;           // Strictly higher source waiting
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      kill_q  <= 1'b0;
    end else begin
      valid_q <= valid_d;
      kill_q  <= kill_d;
    end
  end

  // Payload only loads while nothing is offered
  always_ff @(posedge clk_i) begin
    if (!valid_q) begin
      sel_id_q    <= node_id[0];
      sel_level_q <= node_level[0];
      sel_priv_q  <= node_priv[0];
    end
  end

  assign irq.valid    = valid_q;
  assign irq.id       = sel_id_q;
  assign irq.level    = sel_level_q;
  assign irq.priv     = sel_priv_q;
  assign irq.kill_req = kill_q;

endmodule

//--- clic_subsys.f
+incdir+.
clic_pkg.sv
clic_irq_if.sv
clic_source_arbiter.sv
clic_core_ctrl.sv
clic_csr_regs.sv
clic_subsys.sv
tb_clic_subsys.sv

//--- clic_subsys.sv
// ----------------------------
// Top level of the interrupt subsystem
// Arbiter feeds the core controller, CSRs capture taken irqs
// ----------------------------

`include "clic_consts.svh"

module clic_subsys (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Interrupt sources
  input  logic [`CLIC_NUM_SRC-1:0] src_i,
  // Source configuration strobe
  input  logic                     cfg_we_i,
  input  logic [`CLIC_ID_W-1:0]    cfg_id_i,
  input  logic                     cfg_ie_i,
  input  logic [`CLIC_LEVEL_W-1:0] cfg_level_i,
  input  clic_pkg::priv_lvl_e      cfg_priv_i,
  // CSR write strobe
  input  logic                     csr_we_i,
  input  clic_pkg::csr_sel_e       csr_sel_i,
  input  logic [`CLIC_XLEN-1:0]    csr_wdata_i,
  // Hart side
  input  clic_pkg::priv_lvl_e      priv_lvl_i,
  input  logic                     irq_ack_i,
  output logic                     irq_req_o,
  output logic [`CLIC_XLEN-1:0]    irq_cause_o,
  output logic [`CLIC_XLEN-1:0]    mcause_o,
  output logic [`CLIC_XLEN-1:0]    mintstatus_o
);

  clic_irq_if irq_bus ();

  logic [`CLIC_LEVEL_W-1:0] mintthresh;
  logic [`CLIC_LEVEL_W-1:0] sintthresh;
  clic_pkg::intstatus_u     mintstatus;
  logic                     sie;
  logic                     take;

  assign take         = irq_req_o & irq_ack_i;  // Pipeline accepted the irq
  assign mintstatus_o = mintstatus.raw;

  clic_source_arbiter i_arb (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .src_i       (src_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_id_i    (cfg_id_i),
    .cfg_ie_i    (cfg_ie_i),
    .cfg_level_i (cfg_level_i),
    .cfg_priv_i  (cfg_priv_i),
    .irq         (irq_bus)
  );

  clic_core_ctrl i_core (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .priv_lvl_i   (priv_lvl_i),
    .mintthresh_i (mintthresh),
    .sintthresh_i (sintthresh),
    .mintstatus_i (mintstatus),
    .sie_i        (sie),
    .irq_ack_i    (irq_ack_i),
    .irq          (irq_bus),
    .irq_req_o    (irq_req_o),
    .irq_cause_o  (irq_cause_o)
  );

  clic_csr_regs i_csr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .csr_we_i     (csr_we_i),
    .csr_sel_i    (csr_sel_i),
    .csr_wdata_i  (csr_wdata_i),
    .take_i       (take),
    .take_cause_i (irq_cause_o),
    .take_priv_i  (irq_bus.priv),
    .take_level_i (irq_bus.level),
    .mintthresh_o (mintthresh),
    .sintthresh_o (sintthresh),
    .mintstatus_o (mintstatus),
    .sie_o        (sie),
    .mcause_o     (mcause_o)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f clic_subsys.f \
  --top-module tb_clic_subsys -Mdir obj_dir
./obj_dir/Vtb_clic_subsys | tee sim.log
if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb_clic_subsys.sv
// ----------------------------
// Directed testbench for the CLIC-style interrupt subsystem
// Each scenario is a task run in order from the main block
// ----------------------------

`include "clic_consts.svh"

module tb_clic_subsys;

  localparam int unsigned timeout_cycles = 2000;  // Tests need about 100 cycles in all

  logic                     clk_i;
  logic                     rst_ni;
  logic [`CLIC_NUM_SRC-1:0] src_i;
  logic                     cfg_we_i;
  logic [`CLIC_ID_W-1:0]    cfg_id_i;
  logic                     cfg_ie_i;
  logic [`CLIC_LEVEL_W-1:0] cfg_level_i;
  clic_pkg::priv_lvl_e      cfg_priv_i;
  logic                     csr_we_i;
  clic_pkg::csr_sel_e       csr_sel_i;
  logic [`CLIC_XLEN-1:0]    csr_wdata_i;
  clic_pkg::priv_lvl_e      priv_lvl_i;
  logic                     irq_ack_i;
  logic                     irq_req_o;
  logic [`CLIC_XLEN-1:0]    irq_cause_o;
  logic [`CLIC_XLEN-1:0]    mcause_o;
  logic [`CLIC_XLEN-1:0]    mintstatus_o;

  string       test_name;
  int unsigned cycle_cnt = 0;
  logic [31:0] lcg_state;

  clic_subsys i_dut (.*);

  // ----------------------------
  // Clock, timeout and helpers
  // ----------------------------
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) fail_run("Timeout, simulation ran past its cycle limit");
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else
      fail_run($sformatf("CHECK FAILED %s %s: expected 0x%08h, actual 0x%08h",
                         test_name, what, exp, act));
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_val(what, {31'b0, exp}, {31'b0, act});
  endtask

  // Numerical Recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Cause layout with flag at 31, level at 23..16 and id at 3..0
  function automatic logic [31:0] cause_of(input logic [3:0] id, input logic [7:0] level);
    return {1'b1, 7'b0, level, 12'b0, id};
  endfunction

  function automatic logic [`CLIC_NUM_SRC-1:0] one_hot(input logic [`CLIC_ID_W-1:0] id);
    logic [`CLIC_NUM_SRC-1:0] oh;
    oh     = '0;
    oh[id] = 1'b1;
    return oh;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #2;  // Drive point
  endtask

  task automatic do_reset();
    rst_ni      = 1'b0;
    src_i       = '0;
    cfg_we_i    = 1'b0;
    csr_we_i    = 1'b0;
    irq_ack_i   = 1'b0;
    priv_lvl_i  = clic_pkg::PRIV_M;
    repeat (2) step();
    rst_ni = 1'b1;
  endtask

  task automatic configure(input logic [3:0] id, input logic [7:0] level,
                           input clic_pkg::priv_lvl_e priv);
    cfg_we_i    = 1'b1;
    cfg_id_i    = id;
    cfg_ie_i    = 1'b1;
    cfg_level_i = level;
    cfg_priv_i  = priv;
    step();
    cfg_we_i = 1'b0;
  endtask

  task automatic strobe(input logic [`CLIC_NUM_SRC-1:0] mask);
    src_i = mask;
    step();
    src_i = '0;  // Single-cycle edge
  endtask

  task automatic csr_write(input clic_pkg::csr_sel_e sel, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_sel_i   = sel;
    csr_wdata_i = data;
    step();
    csr_we_i = 1'b0;
  endtask

  task automatic ack_irq();
    irq_ack_i = 1'b1;
    step();
    irq_ack_i = 1'b0;
  endtask

  // Bounded waits followed by a value check
  task automatic wait_req();
    int unsigned n;
    n = 0;
    while (!irq_req_o && n < 8) begin
      step();
      n++;
    end
    check_bit("irq_req_o rise", 1'b1, irq_req_o);
  endtask

  task automatic wait_cause(input logic [31:0] exp);
    int unsigned n;
    n = 0;
    while (irq_cause_o !== exp && n < 8) begin
      step();
      n++;
    end
    check_val("irq_cause_o", exp, irq_cause_o);
  endtask

  // ----------------------------
  // Tests
  // ----------------------------
  task automatic test_basic_take();
    logic [31:0] r;
    logic [31:0] exp_cause;
    test_name = "basic_take";
    do_reset();
    r = lcg_next();
    configure(r[3:0], 8'h40, clic_pkg::PRIV_M);
    strobe(one_hot(r[3:0]));
    step();                                      // Two edges after the strobe
    check_bit("irq_req_o", 1'b1, irq_req_o);
    exp_cause = cause_of(r[3:0], 8'h40);
    check_val("irq_cause_o", exp_cause, irq_cause_o);
    ack_irq();
    check_val("mcause_o", exp_cause, mcause_o);
    check_val("mil", 32'h40, {24'b0, mintstatus_o[31:24]});
  endtask

  task automatic test_threshold();
    logic [31:0] r;
    test_name = "threshold";
    do_reset();
    r = lcg_next();
    csr_write(clic_pkg::CSR_MINTTHRESH, 32'h50);
    configure(r[3:0], 8'h40, clic_pkg::PRIV_M);
    strobe(one_hot(r[3:0]));
    step();
    check_bit("below mintthresh", 1'b0, irq_req_o);
    csr_write(clic_pkg::CSR_MINTSTATUS, 32'h6000_0000);
    check_bit("below mil", 1'b0, irq_req_o);
    csr_write(clic_pkg::CSR_MINTTHRESH, 32'h10);
    check_bit("mil still gates", 1'b0, irq_req_o);
    csr_write(clic_pkg::CSR_MINTSTATUS, 32'h0);
    check_bit("both lowered", 1'b1, irq_req_o);
    check_val("irq_cause_o", cause_of(r[3:0], 8'h40), irq_cause_o);
  endtask

  task automatic test_priv_rules();
    logic [31:0] r;
    logic [3:0]  id_m;
    logic [3:0]  id_s;
    test_name = "priv_rules";
    do_reset();
    r    = lcg_next();
    id_m = r[3:0];
    id_s = r[3:0] ^ (r[7:4] | 4'h1);  // Always differs from id_m
    priv_lvl_i = clic_pkg::PRIV_S;
    csr_write(clic_pkg::CSR_MINTTHRESH, 32'hff);
    csr_write(clic_pkg::CSR_SINTTHRESH, 32'h30);
    configure(id_m, 8'h10, clic_pkg::PRIV_M);
    configure(id_s, 8'h40, clic_pkg::PRIV_S);
    strobe(one_hot(id_m));
    step();
    check_bit("M source in S mode", 1'b1, irq_req_o);
    check_val("irq_cause_o", cause_of(id_m, 8'h10), irq_cause_o);
    ack_irq();
    strobe(one_hot(id_s));
    step();
    check_bit("S source, sie clear", 1'b0, irq_req_o);
    csr_write(clic_pkg::CSR_SIE, 32'h1);
    check_bit("S source, sie set", 1'b1, irq_req_o);
    check_val("irq_cause_o", cause_of(id_s, 8'h40), irq_cause_o);
    ack_irq();
    check_val("sil", 32'h40, {24'b0, mintstatus_o[15:8]});
    strobe(one_hot(id_s));
    step();
    check_bit("S source at sil", 1'b0, irq_req_o);  // Not strictly above
    priv_lvl_i = clic_pkg::PRIV_U;
    step();
    check_bit("any source in U mode", 1'b1, irq_req_o);
    ack_irq();
  endtask

  task automatic test_arbitration();
    logic [31:0] r;
    logic [3:0]  id_a;
    logic [3:0]  id_b;
    logic [7:0]  lvl_a;
    logic [7:0]  lvl_b;
    test_name = "arbitration";
    do_reset();
    priv_lvl_i = clic_pkg::PRIV_U;  // No threshold in the way
    r     = lcg_next();
    id_a  = r[3:0];
    id_b  = r[3:0] ^ (r[7:4] | 4'h1);
    lvl_a = r[15:8] | 8'h01;         // Odd and thus never zero
    lvl_b = r[23:16] | 8'h01;
    if (lvl_b == lvl_a) lvl_b = lvl_a ^ 8'h80;
    configure(id_a, lvl_a, clic_pkg::PRIV_M);
    configure(id_b, lvl_b, clic_pkg::PRIV_M);
    strobe(one_hot(id_a) | one_hot(id_b));
    step();
    check_bit("irq_req_o", 1'b1, irq_req_o);
    if (lvl_a > lvl_b) begin
      check_val("first offer", cause_of(id_a, lvl_a), irq_cause_o);
      ack_irq();
      wait_req();
      check_val("second offer", cause_of(id_b, lvl_b), irq_cause_o);
    end else begin
      check_val("first offer", cause_of(id_b, lvl_b), irq_cause_o);
      ack_irq();
      wait_req();
      check_val("second offer", cause_of(id_a, lvl_a), irq_cause_o);
    end
  endtask

  task automatic test_preempt_kill();
    logic [31:0] r;
    logic [3:0]  id_lo;
    logic [3:0]  id_hi;
    test_name = "preempt_kill";
    do_reset();
    r     = lcg_next();
    id_lo = r[3:0];
    id_hi = r[3:0] ^ (r[7:4] | 4'h1);
    csr_write(clic_pkg::CSR_MINTTHRESH, 32'h50);
    configure(id_lo, 8'h20, clic_pkg::PRIV_M);
    configure(id_hi, 8'h70, clic_pkg::PRIV_M);
    strobe(one_hot(id_lo));
    step();
    check_bit("low source gated", 1'b0, irq_req_o);
    check_val("low offer", cause_of(id_lo, 8'h20), irq_cause_o);
    strobe(one_hot(id_hi));
    wait_req();                                      // Kill and reselect
    check_val("high offer", cause_of(id_hi, 8'h70), irq_cause_o);
    ack_irq();
    wait_cause(cause_of(id_lo, 8'h20));              // Low one still pending
    check_bit("low source under mil", 1'b0, irq_req_o);
  endtask

  task automatic test_inflight_block();
    logic [31:0] r;
    logic [3:0]  id_a;
    logic [3:0]  id_b;
    test_name = "inflight_block";
    do_reset();
    r    = lcg_next();
    id_a = r[3:0];
    id_b = r[3:0] ^ (r[7:4] | 4'h1);
    configure(id_a, 8'h30, clic_pkg::PRIV_M);
    configure(id_b, 8'h60, clic_pkg::PRIV_M);
    strobe(one_hot(id_a));
    step();
    check_bit("irq_req_o", 1'b1, irq_req_o);
    strobe(one_hot(id_b));  // Request up and not acked
    repeat (2) begin
      step();
      check_val("held offer", cause_of(id_a, 8'h30), irq_cause_o);
    end
    // Request drops while the offer stays in flight
    csr_write(clic_pkg::CSR_MINTTHRESH, 32'h40);
    check_bit("request dropped", 1'b0, irq_req_o);
    repeat (2) begin
      step();
      check_val("in-flight offer", cause_of(id_a, 8'h30), irq_cause_o);
    end
    csr_write(clic_pkg::CSR_MINTTHRESH, 32'h0);
    check_bit("request restored", 1'b1, irq_req_o);
    ack_irq();
    wait_req();
    check_val("next offer", cause_of(id_b, 8'h60), irq_cause_o);
  endtask

  // ----------------------------
  // Main sequence
  // ----------------------------
  initial begin
    rst_ni      = 1'b0;
    src_i       = '0;
    cfg_we_i    = 1'b0;
    cfg_id_i    = '0;
    cfg_ie_i    = 1'b0;
    cfg_level_i = '0;
    cfg_priv_i  = clic_pkg::PRIV_M;
    csr_we_i    = 1'b0;
    csr_sel_i   = clic_pkg::CSR_MINTTHRESH;
    csr_wdata_i = '0;
    priv_lvl_i  = clic_pkg::PRIV_M;
    irq_ack_i   = 1'b0;
    lcg_state   = 32'h62af7055;
    test_basic_take();
    test_threshold();
    test_priv_rules();
    test_arbitration();
    test_preempt_kill();
    test_inflight_block();
    $display("Finished with no errors");
    $finish;
  end

endmodule
